//--- include/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ####################
// base sizes
// ####################

`define DCACHE_WORD_SIZE 32   // the core data word in bits.
`define DCACHE_ADDR_SIZE 32   // byte address width.
`define DCACHE_LANE_SIZE 128  // one cache line in bits.
`define DCACHE_NUM_LANES 16

// ####################
// derived sizes
// ####################

// words per line is also the number of fill beats.
`define DCACHE_LANE_WORDS (`DCACHE_LANE_SIZE / `DCACHE_WORD_SIZE)

`define DCACHE_BYTE_SIZE ($clog2(`DCACHE_LANE_SIZE / 8))  // byte offset field.
`define DCACHE_INDEX_SIZE ($clog2(`DCACHE_NUM_LANES))
`define DCACHE_TAG_SIZE (`DCACHE_ADDR_SIZE - `DCACHE_INDEX_SIZE - `DCACHE_BYTE_SIZE)

`endif

//--- source/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    // ####################
    // access size
    // ####################

    // the address must be aligned to the access size.
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_size_e;

    // ####################
    // address layout
    // ####################

    typedef struct packed {
        logic [`DCACHE_TAG_SIZE-1:0]   tag;
        logic [`DCACHE_INDEX_SIZE-1:0] index;
        logic [`DCACHE_BYTE_SIZE-1:0]  offset;  // byte within the line.
    } dcache_addr_s;

    // the same address seen either as a plain word or split into its fields.
    typedef union packed {
        logic [`DCACHE_ADDR_SIZE-1:0] raw;
        dcache_addr_s                 f;
    } dcache_addr_u;

endpackage : dcache_pkg

//--- source/dcache_array_if.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

interface dcache_array_if import dcache_pkg::*; ();

    logic [`DCACHE_INDEX_SIZE-1:0] index;
    logic [`DCACHE_BYTE_SIZE-1:0]  offset;
    memop_size_e                   size;
    logic [`DCACHE_WORD_SIZE-1:0]  wdata;   // store data arrives low aligned from the core.
    logic                          rd_en;
    logic                          wr_en;
    logic                          fill_en;
    logic [`DCACHE_LANE_SIZE-1:0]  fill_data;
    logic                          tag_wr_en;
    logic [`DCACHE_TAG_SIZE-1:0]   tag_wr;  // the current tag is both compared and written.
    logic [`DCACHE_WORD_SIZE-1:0]  rdata;
    logic                          hit;

    modport ctrl (
        output index, offset, size, wdata, rd_en, wr_en, fill_en, fill_data,
        output tag_wr_en, tag_wr,
        input  rdata, hit
    );

    modport data (
        input  index, offset, size, wdata, rd_en, wr_en, fill_en, fill_data,
        output rdata
    );

    modport tag (
        input  index, tag_wr_en, tag_wr,
        output hit
    );

endinterface : dcache_array_if

//--- source/dcache_mem_if.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

interface dcache_mem_if ();

    // req stays high until done and the fields are taken on its first cycle.
    logic                           req;
    logic                           we;
    logic [`DCACHE_ADDR_SIZE-1:0]   addr;
    logic [`DCACHE_WORD_SIZE-1:0]   wdata;
    logic [`DCACHE_WORD_SIZE/8-1:0] sel;

    // done is a single cycle pulse.
    logic                           done;
    logic [`DCACHE_LANE_SIZE-1:0]   fill_data;

    modport ctrl (
        output req, we, addr, wdata, sel,
        input  done, fill_data
    );

    modport wb (
        input  req, we, addr, wdata, sel,
        output done, fill_data
    );

endinterface : dcache_mem_if

//--- source/dcache_data.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data import dcache_pkg::*; (
    input logic        clk_i,
    input logic        rst_n_i,
    dcache_array_if.data arr
);

    // lanes stored byte by byte so that stores can hit single bytes.
    logic [`DCACHE_NUM_LANES-1:0][`DCACHE_LANE_SIZE/8-1:0][7:0] lanes;

    logic [`DCACHE_BYTE_SIZE-1:0] half_lo;
    logic [`DCACHE_BYTE_SIZE-1:0] half_hi;
    logic [`DCACHE_BYTE_SIZE-1:0] word_b0;
    logic [`DCACHE_BYTE_SIZE-1:0] word_b1;
    logic [`DCACHE_BYTE_SIZE-1:0] word_b2;
    logic [`DCACHE_BYTE_SIZE-1:0] word_b3;

    // byte positions inside the aligned half and word that hold the offset.
    assign half_lo = {arr.offset[`DCACHE_BYTE_SIZE-1:1], 1'b0};
    assign half_hi = {arr.offset[`DCACHE_BYTE_SIZE-1:1], 1'b1};
    assign word_b0 = {arr.offset[`DCACHE_BYTE_SIZE-1:2], 2'b00};
    assign word_b1 = {arr.offset[`DCACHE_BYTE_SIZE-1:2], 2'b01};
    assign word_b2 = {arr.offset[`DCACHE_BYTE_SIZE-1:2], 2'b10};
    assign word_b3 = {arr.offset[`DCACHE_BYTE_SIZE-1:2], 2'b11};

    // ####################
    // write port
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lanes <= '0;
        end else if (arr.wr_en) begin  // a core store wins over a fill.
            unique case (arr.size)
                BYTE: lanes[arr.index][arr.offset] <= arr.wdata[7:0];
                HALF: begin
                    lanes[arr.index][half_hi] <= arr.wdata[15:8];
                    lanes[arr.index][half_lo] <= arr.wdata[7:0];
                end
                WORD: begin
                    lanes[arr.index][word_b3] <= arr.wdata[31:24];
                    lanes[arr.index][word_b2] <= arr.wdata[23:16];
                    lanes[arr.index][word_b1] <= arr.wdata[15:8];
                    lanes[arr.index][word_b0] <= arr.wdata[7:0];
                end
                default: ;
            endcase
        end else if (arr.fill_en) begin
            lanes[arr.index] <= arr.fill_data;
        end
    end

    // ####################
    // read port
    // ####################

    always_ff @(posedge clk_i) begin
        if (arr.rd_en) begin
            arr.rdata <= {lanes[arr.index][word_b3], lanes[arr.index][word_b2],
                          lanes[arr.index][word_b1], lanes[arr.index][word_b0]};
        end
    end

endmodule : dcache_data

//--- source/dcache_tag.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tag (
    input logic       clk_i,
    input logic       rst_n_i,
    dcache_array_if.tag arr
);

    logic [`DCACHE_NUM_LANES-1:0][`DCACHE_TAG_SIZE-1:0] tags;
    logic [`DCACHE_NUM_LANES-1:0]                       valid;

    // ####################
    // lookup
    // ####################

    // a line hits only once it has been filled.
    assign arr.hit = valid[arr.index] && (tags[arr.index] == arr.tag_wr);

    // ####################
    // update
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tags  <= '0;
            valid <= '0;
        end else if (arr.tag_wr_en) begin
            tags[arr.index]  <= arr.tag_wr;
            valid[arr.index] <= 1'b1;  // written together with the fill.
        end
    end

endmodule : dcache_tag

//--- source/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_valid_i,
    input  logic                          req_we_i,
    input  logic [`DCACHE_ADDR_SIZE-1:0]  req_addr_i,
    input  memop_size_e                   req_size_i,
    input  logic [`DCACHE_WORD_SIZE-1:0]  req_wdata_i,
    output logic                          req_ready_o,
    output logic                          rsp_valid_o,
    output logic [`DCACHE_WORD_SIZE-1:0]  rsp_rdata_o,
    dcache_array_if.ctrl                  arr,
    dcache_mem_if.ctrl                    mem
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        READ,
        FILL,
        WRITE,
        RESP
    } state_e;

    state_e state_q;
    state_e state_d;

    dcache_addr_u                   addr_q;
    logic                           we_q;
    memop_size_e                    size_q;
    logic [`DCACHE_WORD_SIZE-1:0]   wdata_q;
    logic [`DCACHE_WORD_SIZE/8-1:0] sel;

    // ####################
    // request capture
    // ####################

    assign req_ready_o = (state_q == IDLE);

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            addr_q.raw <= req_addr_i;
            we_q       <= req_we_i;
            size_q     <= req_size_i;
            wdata_q    <= req_wdata_i;
        end
    end

    // ####################
    // fsm
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:    if (req_valid_i) state_d = LOOKUP;
            LOOKUP: begin
                // stores always go to memory, hit or not.
                if (we_q) begin
                    state_d = WRITE;
                end else if (arr.hit) begin
                    state_d = READ;
                end else begin
                    state_d = FILL;
                end
            end
            FILL:    if (mem.done) state_d = READ;
            READ:    state_d = RESP;
            WRITE:   if (mem.done) state_d = RESP;
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // ####################
    // array side
    // ####################

    assign arr.index     = addr_q.f.index;
    assign arr.offset    = addr_q.f.offset;
    assign arr.size      = size_q;
    assign arr.wdata     = wdata_q;
    assign arr.tag_wr    = addr_q.f.tag;
    assign arr.rd_en     = (state_q == READ);
    assign arr.wr_en     = (state_q == LOOKUP) && we_q && arr.hit;  // no write allocate.
    assign arr.fill_en   = (state_q == FILL) && mem.done;
    assign arr.fill_data = mem.fill_data;
    assign arr.tag_wr_en = (state_q == FILL) && mem.done;

    // ####################
    // memory side
    // ####################

    always_comb begin
        unique case (size_q)
            BYTE:    sel = 4'b0001 << addr_q.f.offset[1:0];
            HALF:    sel = 4'b0011 << {addr_q.f.offset[1], 1'b0};
            default: sel = 4'b1111;
        endcase
    end

    assign mem.req   = (state_q == FILL) || (state_q == WRITE);
    assign mem.we    = we_q;
    assign mem.sel   = sel;
    assign mem.wdata = wdata_q << {addr_q.f.offset[1:0], 3'b000};

    // fills start at the line base and stores go to their aligned word.
    assign mem.addr = we_q ? {addr_q.raw[`DCACHE_ADDR_SIZE-1:2], 2'b00}
                           : {addr_q.f.tag, addr_q.f.index, {`DCACHE_BYTE_SIZE{1'b0}}};

    assign rsp_valid_o = (state_q == RESP);
    assign rsp_rdata_o = arr.rdata;

endmodule : dcache_ctrl

//--- source/dcache_wb_master.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_wb_master (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    dcache_mem_if.wb                       mem,
    output logic                           wb_cyc_o,
    output logic                           wb_stb_o,
    output logic                           wb_we_o,
    output logic [`DCACHE_ADDR_SIZE-1:0]   wb_adr_o,
    output logic [`DCACHE_WORD_SIZE-1:0]   wb_dat_o,
    output logic [`DCACHE_WORD_SIZE/8-1:0] wb_sel_o,
    input  logic [`DCACHE_WORD_SIZE-1:0]   wb_dat_i,
    input  logic                           wb_ack_i
);

    typedef enum logic [1:0] {
        IDLE,
        CYCLE,
        GAP,
        DONE
    } state_e;

    state_e state_q;

    logic [`DCACHE_ADDR_SIZE-1:0]                         adr_q;
    logic                                                 we_q;
    logic [`DCACHE_WORD_SIZE-1:0]                         wdata_q;
    logic [`DCACHE_WORD_SIZE/8-1:0]                       sel_q;
    logic [$clog2(`DCACHE_LANE_WORDS)-1:0]                beat_q;
    logic [`DCACHE_LANE_WORDS-1:0][`DCACHE_WORD_SIZE-1:0] fill_q;

    // ####################
    // sequencer
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            beat_q  <= '0;
        end else begin
            unique case (state_q)
                IDLE: begin
                    beat_q <= '0;
                    if (mem.req) state_q <= CYCLE;
                end
                CYCLE: begin
                    if (wb_ack_i) begin
                        if (we_q || (beat_q == 2'(`DCACHE_LANE_WORDS - 1))) begin
                            state_q <= DONE;
                        end else begin
                            beat_q  <= beat_q + 1'b1;
                            state_q <= GAP;  // cyc and stb low for one cycle between beats.
                        end
                    end
                end
                GAP:     state_q <= CYCLE;
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // fields are taken once, so the bus outputs hold until ack.
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && mem.req) begin
            adr_q   <= mem.addr;
            we_q    <= mem.we;
            wdata_q <= mem.wdata;
            sel_q   <= mem.sel;
        end
        if ((state_q == CYCLE) && wb_ack_i && !we_q) fill_q[beat_q] <= wb_dat_i;
    end

    // ####################
    // bus outputs
    // ####################

    assign wb_cyc_o = (state_q == CYCLE);
    assign wb_stb_o = (state_q == CYCLE);
    assign wb_we_o  = we_q;
    assign wb_dat_o = wdata_q;
    assign wb_sel_o = sel_q;
    assign wb_adr_o = {adr_q[`DCACHE_ADDR_SIZE-1:`DCACHE_BYTE_SIZE],
                       adr_q[`DCACHE_BYTE_SIZE-1:2] | beat_q, 2'b00};  // ascending words.

    assign mem.done      = (state_q == DONE);
    assign mem.fill_data = fill_q;

endmodule : dcache_wb_master

//--- source/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // core request and response.
    input  logic                           req_valid_i,
    input  logic                           req_we_i,
    input  logic [`DCACHE_ADDR_SIZE-1:0]   req_addr_i,
    input  memop_size_e                    req_size_i,
    input  logic [`DCACHE_WORD_SIZE-1:0]   req_wdata_i,
    output logic                           req_ready_o,
    output logic                           rsp_valid_o,
    output logic [`DCACHE_WORD_SIZE-1:0]   rsp_rdata_o,

    // wishbone classic master.
    output logic                           wb_cyc_o,
    output logic                           wb_stb_o,
    output logic                           wb_we_o,
    output logic [`DCACHE_ADDR_SIZE-1:0]   wb_adr_o,
    output logic [`DCACHE_WORD_SIZE-1:0]   wb_dat_o,
    output logic [`DCACHE_WORD_SIZE/8-1:0] wb_sel_o,
    input  logic [`DCACHE_WORD_SIZE-1:0]   wb_dat_i,
    input  logic                           wb_ack_i
);

    dcache_array_if arr_if ();
    dcache_mem_if   mem_if ();

    dcache_ctrl ctrl0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_size_i  (req_size_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .arr         (arr_if.ctrl),
        .mem         (mem_if.ctrl)
    );

    dcache_tag tag0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .arr(arr_if.tag));

    dcache_data data0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .arr(arr_if.data));

    dcache_wb_master wbm0 (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .mem      (mem_if.wb),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

endmodule : dcache_top

//--- dv/tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);

    logic [31:0] words [logic [29:0]];  // only words that were written are kept.
    logic [31:0] lcg_q;
    logic [1:0]  wait_q;
    logic [31:0] word;

    // untouched memory reads as a mix of the whole word address.
    function automatic logic [31:0] fill_word(input logic [29:0] waddr);
        return ({2'b00, waddr} * 32'h9e3779b1) ^ 32'h0f1ec3a5;
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        wb_ack_o = 1'b0;
        wb_dat_o = '0;
    end

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            wait_q   <= '0;
            lcg_q    <= 32'h8d013efd;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;  // one ack per classic cycle.
            wait_q   <= '0;
            lcg_q    <= lcg_step(lcg_q);
        end else if (wb_cyc_i && wb_stb_i) begin
            if (wait_q == lcg_q[31:30]) begin  // between 0 and 3 wait cycles.
                word = words.exists(wb_adr_i[31:2]) ? words[wb_adr_i[31:2]]
                                                    : fill_word(wb_adr_i[31:2]);
                if (wb_we_i) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wb_sel_i[i]) word[8*i +: 8] = wb_dat_i[8*i +: 8];
                    end
                    words[wb_adr_i[31:2]] = word;
                end
                wb_dat_o <= word;
                wb_ack_o <= 1'b1;
            end else begin
                wait_q <= wait_q + 2'd1;
            end
        end
    end

endmodule : tb_wb_mem

//--- dv/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int WAIT_LIMIT = 100;  // a fill with the slowest acks needs far fewer cycles.

    typedef struct packed {
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } bus_beat_s;

    logic                           clk_i;
    logic                           rst_n_i;
    logic                           req_valid_i;
    logic                           req_we_i;
    logic [`DCACHE_ADDR_SIZE-1:0]   req_addr_i;
    memop_size_e                    req_size_i;
    logic [`DCACHE_WORD_SIZE-1:0]   req_wdata_i;
    logic                           req_ready_o;
    logic                           rsp_valid_o;
    logic [`DCACHE_WORD_SIZE-1:0]   rsp_rdata_o;
    logic                           wb_cyc_o;
    logic                           wb_stb_o;
    logic                           wb_we_o;
    logic [`DCACHE_ADDR_SIZE-1:0]   wb_adr_o;
    logic [`DCACHE_WORD_SIZE-1:0]   wb_dat_o;
    logic [`DCACHE_WORD_SIZE/8-1:0] wb_sel_o;
    logic [`DCACHE_WORD_SIZE-1:0]   wb_dat_i;
    logic                           wb_ack_i;

    logic [7:0]  shadow [logic [31:0]];  // unstored bytes read as the fill pattern.
    logic [23:0] line_tag [16];
    logic        line_valid [16];
    bus_beat_s   bus_log [$];
    logic        busy_q;
    logic [31:0] rand_state;

    dcache_top dut0 (.*);

    tb_wb_mem mem0 (
        .clk_i    (clk_i),    .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_o), .wb_stb_i (wb_stb_o), .wb_we_i  (wb_we_o),
        .wb_adr_i (wb_adr_o), .wb_dat_i (wb_dat_o), .wb_sel_i (wb_sel_o),
        .wb_dat_o (wb_dat_i), .wb_ack_o (wb_ack_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // ####################
    // bus and port rules
    // ####################

    always @(posedge clk_i) begin
        if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
            bus_log.push_back({wb_we_o, wb_sel_o, wb_adr_o, wb_dat_o});
        end
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            busy_q <= 1'b1;
        end else if (rsp_valid_o) begin
            busy_q <= 1'b0;
        end
    end

    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_stb_o |-> wb_cyc_o)
        else abort_run("wb_stb_o was high while wb_cyc_o was low");
    rise_together: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(wb_cyc_o) |-> $rose(wb_stb_o))
        else abort_run("wb_cyc_o rose without wb_stb_o");
    hold_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_cyc_o && wb_stb_o && !wb_ack_i) |=> (wb_cyc_o && wb_stb_o && $stable(wb_we_o)
        && $stable(wb_adr_o) && $stable(wb_sel_o) && $stable(wb_dat_o)))
        else abort_run("the Wishbone outputs changed before wb_ack_i");
    ready_low_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy_q |-> !req_ready_o)
        else abort_run("req_ready_o was high while a request was in flight");
    rsp_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |=> (!rsp_valid_o && req_ready_o))
        else abort_run("rsp_valid_o was not a single pulse followed by req_ready_o");
    idle_after_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> (req_ready_o && !rsp_valid_o && !wb_cyc_o && !wb_stb_o))
        else abort_run("the outputs were not idle after reset");

    // ####################
    // reference model
    // ####################

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [7:0] model_byte(input logic [31:0] addr);
        logic [31:0] w;
        if (shadow.exists(addr)) return shadow[addr];
        w = ({2'b00, addr[31:2]} * 32'h9e3779b1) ^ 32'h0f1ec3a5;  // same pattern as memory.
        return w[8*int'(addr[1:0]) +: 8];
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        return {model_byte(base + 32'd3), model_byte(base + 32'd2),
                model_byte(base + 32'd1), model_byte(base)};
    endfunction

    function automatic int size_bytes(input memop_size_e size);
        case (size)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    // ####################
    // core accesses
    // ####################

    task automatic do_access(input logic we, input logic [31:0] addr, input memop_size_e size,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int latency);
        int waited;
        waited = 0;
        bus_log.delete();
        req_valid_i <= 1'b1;
        req_we_i    <= we;
        req_addr_i  <= addr;
        req_size_i  <= size;
        req_wdata_i <= wdata;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("timed out waiting for req_ready_o");
        end while (!req_ready_o);
        req_valid_i <= 1'b0;
        latency = 0;
        do begin
            @(posedge clk_i);
            latency++;
            if (latency > WAIT_LIMIT) abort_run("timed out waiting for rsp_valid_o");
        end while (!rsp_valid_o);
        rdata = rsp_rdata_o;
    endtask

    task automatic check_load(input logic [31:0] addr, input memop_size_e size);
        logic [31:0] rdata;
        logic [31:0] expected;
        int          latency;
        logic        cached;
        cached   = line_valid[addr[7:4]] && (line_tag[addr[7:4]] == addr[31:8]);
        expected = model_word(addr);
        do_access(1'b0, addr, size, 32'h0, rdata, latency);
        assert (rdata == expected) else abort_run($sformatf(
            "Error at %0t: load of %h returned %h, expected %h", $time, addr, rdata, expected));
        if (cached) begin
            // rsp_valid_o rises two cycles after acceptance, so the third edge first sees it.
            assert (bus_log.size() == 0 && latency == 3) else abort_run($sformatf(
                "Error at %0t: hit on %h took %0d cycles and %0d bus cycles",
                $time, addr, latency, bus_log.size()));
        end else begin
            assert (bus_log.size() == 4) else abort_run($sformatf(
                "Error at %0t: miss on %h made %0d bus cycles", $time, addr, bus_log.size()));
            for (int i = 0; i < 4; i++) begin
                assert (!bus_log[i].we && bus_log[i].adr == {addr[31:4], 4'h0} + 32'(4 * i))
                    else abort_run($sformatf("Error at %0t: fill beat %0d of %h went to %h",
                                             $time, i, addr, bus_log[i].adr));
            end
            line_valid[addr[7:4]] = 1'b1;
            line_tag[addr[7:4]]   = addr[31:8];
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input memop_size_e size,
                               input logic [31:0] wdata);
        logic [31:0] rdata;
        logic [3:0]  sel;
        int          latency;
        int          lane;
        sel = 4'b0000;
        for (int i = 0; i < size_bytes(size); i++) sel[int'(addr[1:0]) + i] = 1'b1;
        do_access(1'b1, addr, size, wdata, rdata, latency);
        assert (bus_log.size() == 1) else abort_run($sformatf(
            "Error at %0t: store to %h made %0d bus cycles", $time, addr, bus_log.size()));
        assert (bus_log[0].we && bus_log[0].adr == {addr[31:2], 2'b00} && bus_log[0].sel == sel)
            else abort_run($sformatf("Error at %0t: store to %h went to %h with sel %b",
                                     $time, addr, bus_log[0].adr, bus_log[0].sel));
        for (int i = 0; i < size_bytes(size); i++) begin
            lane = int'(addr[1:0]) + i;
            assert (bus_log[0].dat[8*lane +: 8] == wdata[8*i +: 8])
                else abort_run($sformatf("Error at %0t: store to %h put %h on byte lane %0d",
                                         $time, addr, bus_log[0].dat[8*lane +: 8], lane));
            shadow[addr + 32'(i)] = wdata[8*i +: 8];
        end
    endtask

    // ####################
    // stimulus
    // ####################

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        memop_size_e size;
        rand_state  = 32'h8d013efd;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_size_i  = WORD;
        req_wdata_i = '0;
        for (int i = 0; i < 16; i++) line_valid[i] = 1'b0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        check_load(32'h0000_1000, WORD);  // fill, then hits on the same line.
        check_load(32'h0000_1004, WORD);
        check_load(32'h0000_100e, HALF);

        check_load(32'h0000_2000, WORD);
        for (int off = 0; off < 16; off++) begin
            check_store(32'h0000_2000 + 32'(off), BYTE, next_rand());
            check_load(32'h0000_2000 + 32'(off), BYTE);
        end
        for (int off = 0; off < 16; off += 2) begin
            check_store(32'h0000_2000 + 32'(off), HALF, next_rand());
            check_load(32'h0000_2000 + 32'(off), HALF);
        end
        for (int off = 0; off < 16; off += 4) begin
            check_store(32'h0000_2000 + 32'(off), WORD, next_rand());
            check_load(32'h0000_2000 + 32'(off), WORD);
        end

        check_store(32'h0000_3004, WORD, 32'hcafe_f00d);  // line not cached, no allocate.
        check_store(32'h0000_3009, BYTE, 32'h0000_005a);
        check_load(32'h0000_3004, WORD);
        check_load(32'h0000_3008, WORD);

        check_load(32'h0000_4040, WORD);  // same index, different tags.
        check_load(32'h0001_4040, WORD);
        check_load(32'h0000_4044, WORD);
        check_store(32'h0001_4048, HALF, 32'h0000_beef);
        check_load(32'h0001_4048, WORD);
        check_load(32'h0000_4040, WORD);

        for (int n = 0; n < 200; n++) begin
            r = next_rand();
            case (r[25:24])
                2'd0:    size = BYTE;
                2'd1:    size = HALF;
                default: size = WORD;
            endcase
            addr = 32'h0001_0000 | {20'h0, r[17:16], 2'b00, r[7:0]};  // four tags per index.
            addr = addr & ~32'(size_bytes(size) - 1);
            if (r[28]) begin
                check_store(addr, size, next_rand());
            end else begin
                check_load(addr, size);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_dcache

//--- project.f
+incdir+include
source/dcache_pkg.sv
source/dcache_array_if.sv
source/dcache_mem_if.sv
source/dcache_data.sv
source/dcache_tag.sv
source/dcache_ctrl.sv
source/dcache_wb_master.sv
source/dcache_top.sv
dv/tb_wb_mem.sv
dv/tb_dcache.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build output"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_dcache -f project.f -Mdir build
	./build/Vtb_dcache

clean:
	rm -rf build
